/* logic/Processor_settings.svh */
`ifndef PROCESSOR_SETTINGS_SVH
`define PROCESSOR_SETTINGS_SVH

// ---------------------------------------------------------
// Instruction cache build options
// ---------------------------------------------------------

// 1 builds the L1 instruction cache, 0 joins the buses by wires
`define RV_ICACHE_ON 1

// Number of one-word lines, power of two
`define RV_ICACHE_LINES 16

// ---------------------------------------------------------
// Core start-up
// ---------------------------------------------------------

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* logic/Types.sv */
package Types;

    // ---------------------------------------------------------
    // Instruction bus
    // ---------------------------------------------------------

    typedef logic [31:0] InstAddr; // Byte address, instruction bus
    typedef logic [31:0] Inst;     // Raw instruction word

    // ---------------------------------------------------------
    // Data bus and register file
    // ---------------------------------------------------------

    typedef logic [31:0] DataAddr; // Byte address, data bus
    typedef logic [31:0] Data;     // Data word / register value
    typedef logic [4:0]  RegIdx;   // x0..x31

endpackage

/* logic/Isa.sv */
package Isa;

    // ---------------------------------------------------------
    // Opcodes, RV32I subset
    // ---------------------------------------------------------

    localparam logic [6:0] OPC_LUI    = 7'b0110111; // U-type
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011; // ADDI only
    localparam logic [6:0] OPC_OP     = 7'b0110011; // R-type
    localparam logic [6:0] OPC_LOAD   = 7'b0000011; // LW only
    localparam logic [6:0] OPC_STORE  = 7'b0100011; // SW only
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // BEQ, BNE
    localparam logic [6:0] OPC_JAL    = 7'b1101111; // J-type

    // funct3 fields
    localparam logic [2:0] F3_ADD = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7 fields
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // ALU operation select, PASSB for LUI
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASSB
    } AluOp;

    // Multicycle core sequence
    typedef enum logic [1:0] {FETCH, EXECUTE, MEMORY, WRITEBACK} CoreState;

endpackage

/* logic/RegisterFile.sv */
`timescale 1ns/1ps

module RegisterFile (
    input  logic         i_clock,   // Clock
    input  logic         i_rst,     // Sync reset, clears all registers
    input  Types::RegIdx i_rs1,     // Read port A
    input  Types::RegIdx i_rs2,     // Read port B
    output Types::Data   o_rs1Data,
    output Types::Data   o_rs2Data,
    input  logic         i_we,      // Write port
    input  Types::RegIdx i_rd,
    input  Types::Data   i_rdData);

    Types::Data regs [32];

    // Async reads, x0 stays zero since it is never written
    assign o_rs1Data = regs[i_rs1];
    assign o_rs2Data = regs[i_rs2];

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != 5'd0)) begin
            regs[i_rd] <= i_rdData;              // x0 writes dropped
        end
    end

endmodule

/* logic/Alu.sv */
`timescale 1ns/1ps

module Alu (
    input  Isa::AluOp  i_op,      // Operation select
    input  Types::Data i_a,       // rs1
    input  Types::Data i_b,       // rs2 or immediate
    output Types::Data o_result);

    logic lessThan;

    // Signed compare for SLT
    assign lessThan = $signed(i_a) < $signed(i_b);

    always_comb begin
        case (i_op)
            Isa::ALU_ADD:   o_result = i_a + i_b;
            Isa::ALU_SUB:   o_result = i_a - i_b;
            Isa::ALU_AND:   o_result = i_a & i_b;
            Isa::ALU_OR:    o_result = i_a | i_b;
            Isa::ALU_XOR:   o_result = i_a ^ i_b;
            Isa::ALU_SLT:   o_result = {31'd0, lessThan};  // 0 or 1
            Isa::ALU_PASSB: o_result = i_b;                // LUI
            default:        o_result = i_a + i_b;
        endcase
    end

endmodule

/* logic/InstL1Cache.sv */
`timescale 1ns/1ps
`include "Processor_settings.svh"

module InstL1Cache #(
    parameter int Lines = `RV_ICACHE_LINES)  // Power of two
(
    input  logic           i_clock,     // Clock
    input  logic           i_rst,       // Sync reset, active high
    input  Types::InstAddr i_coreAddr,  // Local bus, from core
    input  logic           i_coreRe,
    output Types::Inst     o_coreInst,
    output logic           o_coreBusy,
    output Types::InstAddr o_memAddr,   // Global bus, to memory
    output logic           o_memRe,
    input  Types::Inst     i_memInst,
    input  logic           i_memBusy);

    localparam int IndexBits = $clog2(Lines); // Word-address bits for the index
    localparam int TagBits   = 30 - IndexBits; // Rest of the word address

    typedef enum logic {IDLE, FILL} FillState;

    FillState state;                          // Refill FSM

    logic                 lineValid [Lines];  // Cleared on reset
    logic [TagBits-1:0]   lineTag   [Lines];
    Types::Inst           lineData  [Lines];

    logic [IndexBits-1:0] index;
    logic [TagBits-1:0]   tag;
    logic                 hit;
    logic                 fillDone;

    // ---------------------------------------------------------
    // Lookup
    // ---------------------------------------------------------

    assign index = i_coreAddr[IndexBits+1:2];    // Skip byte offset
    assign tag   = i_coreAddr[31:IndexBits+2];

    assign hit = lineValid[index] && (lineTag[index] == tag); // Registered tags

    assign o_coreInst = lineData[index];          // Valid only on a hit
    assign o_coreBusy = i_coreRe && !hit;         // Stall until the line is in

    // ---------------------------------------------------------
    // Refill from global bus
    // ---------------------------------------------------------

    assign o_memAddr = i_coreAddr;                // Core holds it during the miss
    assign o_memRe   = (state == FILL);
    assign fillDone  = o_memRe && !i_memBusy;     // Global transfer completes

    // Fill FSM and valid bits
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state <= IDLE;
            for (int i = 0; i < Lines; i++) begin
                lineValid[i] <= 1'b0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (i_coreRe && !hit) begin
                        state <= FILL;            // Miss detected
                    end
                end
                FILL: begin
                    if (fillDone) begin
                        lineValid[index] <= 1'b1;
                        state            <= IDLE; // Request hits next cycle
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Line payload, no reset
    always_ff @(posedge i_clock) begin
        if (fillDone) begin
            lineTag[index]  <= tag;
            lineData[index] <= i_memInst;
        end
    end

endmodule

/* logic/CoreMC.sv */
`timescale 1ns/1ps
`include "Processor_settings.svh"

module CoreMC (
    input  logic           i_clock,     // Clock
    input  logic           i_rst,       // Sync reset, active high
    output Types::InstAddr o_instAddr,  // Instruction bus master
    output logic           o_instRe,
    input  Types::Inst     i_inst,
    input  logic           i_instBusy,
    output Types::DataAddr o_dataAddr,  // Data bus master
    output logic           o_dataRe,
    output logic           o_dataWe,
    output Types::Data     o_dataWdata,
    input  Types::Data     i_dataRdata,
    input  logic           i_dataBusy);

    Isa::CoreState  state;
    logic           running;     // Low through reset, delays first fetch
    Types::InstAddr pc;
    Types::InstAddr pcNext;      // Latched in EXECUTE
    Types::InstAddr pcPlus4;
    Types::Inst     ir;          // Instruction register
    Types::Data     aluOut;      // Latched ALU result / memory address
    Types::Data     loadData;    // Latched LW data

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    Types::RegIdx   rs1;
    Types::RegIdx   rs2;
    Types::RegIdx   rd;

    Types::Data     immI;
    Types::Data     immS;
    Types::Data     immB;
    Types::Data     immU;
    Types::Data     immJ;

    Types::Data     rs1Data;
    Types::Data     rs2Data;
    Types::Data     aluB;
    Types::Data     aluResult;
    Types::Data     rdData;
    Isa::AluOp      aluOp;

    logic           isLoad;
    logic           isStore;
    logic           isJal;
    logic           writesRd;
    logic           branchTaken;
    logic           regWe;

    // ---------------------------------------------------------
    // Decode
    // ---------------------------------------------------------

    assign opcode = ir[6:0];
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign funct7 = ir[31:25];

    assign immI = {{20{ir[31]}}, ir[31:20]};
    assign immS = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign immB = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign immU = {ir[31:12], 12'd0};
    assign immJ = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    assign isLoad   = (opcode == Isa::OPC_LOAD);
    assign isStore  = (opcode == Isa::OPC_STORE);
    assign isJal    = (opcode == Isa::OPC_JAL);
    assign writesRd = opcode inside {Isa::OPC_LUI, Isa::OPC_OPIMM, Isa::OPC_OP,
                                     Isa::OPC_LOAD, Isa::OPC_JAL};

    // ALU operation and B operand
    always_comb begin
        aluOp = Isa::ALU_ADD;                    // ADDI, LW, SW addresses
        aluB  = immI;
        case (opcode)
            Isa::OPC_LUI: begin
                aluOp = Isa::ALU_PASSB;
                aluB  = immU;
            end
            Isa::OPC_OP: begin
                aluB = rs2Data;
                case (funct3)
                    Isa::F3_ADD: aluOp = (funct7 == Isa::F7_SUB) ? Isa::ALU_SUB
                                                                  : Isa::ALU_ADD;
                    Isa::F3_SLT: aluOp = Isa::ALU_SLT;
                    Isa::F3_XOR: aluOp = Isa::ALU_XOR;
                    Isa::F3_OR:  aluOp = Isa::ALU_OR;
                    Isa::F3_AND: aluOp = Isa::ALU_AND;
                    default:     aluOp = Isa::ALU_ADD;
                endcase
            end
            Isa::OPC_STORE: aluB = immS;
            default: ;
        endcase
    end

    // BEQ / BNE resolution
    always_comb begin
        branchTaken = 1'b0;
        if (opcode == Isa::OPC_BRANCH) begin
            case (funct3)
                Isa::F3_BEQ: branchTaken = (rs1Data == rs2Data);
                Isa::F3_BNE: branchTaken = (rs1Data != rs2Data);
                default:     branchTaken = 1'b0;
            endcase
        end
    end

    // ---------------------------------------------------------
    // Datapath
    // ---------------------------------------------------------

    assign pcPlus4 = pc + 32'd4;
    assign regWe   = (state == Isa::WRITEBACK) && writesRd;
    assign rdData  = isLoad ? loadData : (isJal ? pcPlus4 : aluOut); // Link = PC+4

    RegisterFile regFile (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_rs1     (rs1),
        .i_rs2     (rs2),
        .o_rs1Data (rs1Data),
        .o_rs2Data (rs2Data),
        .i_we      (regWe),
        .i_rd      (rd),
        .i_rdData  (rdData));

    Alu alu (
        .i_op     (aluOp),
        .i_a      (rs1Data),
        .i_b      (aluB),
        .o_result (aluResult));

    // Bus outputs
    assign o_instAddr  = pc;
    assign o_instRe    = running && (state == Isa::FETCH);
    assign o_dataAddr  = aluOut;
    assign o_dataRe    = (state == Isa::MEMORY) && isLoad;
    assign o_dataWe    = (state == Isa::MEMORY) && isStore;
    assign o_dataWdata = rs2Data;                // Held stable, regs unchanged

    // ---------------------------------------------------------
    // State machine
    // ---------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state   <= Isa::FETCH;
            pc      <= `RV_RESET_PC;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            case (state)
                Isa::FETCH: begin
                    if (o_instRe && !i_instBusy) begin
                        state <= Isa::EXECUTE;   // Instruction accepted
                    end
                end
                Isa::EXECUTE: begin
                    state <= (isLoad || isStore) ? Isa::MEMORY : Isa::WRITEBACK;
                end
                Isa::MEMORY: begin
                    if (!i_dataBusy) begin
                        state <= Isa::WRITEBACK;
                    end
                end
                Isa::WRITEBACK: begin
                    pc    <= pcNext;
                    state <= Isa::FETCH;
                end
                default: state <= Isa::FETCH;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge i_clock) begin
        if (o_instRe && !i_instBusy) begin
            ir <= i_inst;
        end
        if (state == Isa::EXECUTE) begin
            aluOut <= aluResult;
            if (isJal) begin
                pcNext <= pc + immJ;             // Jump target
            end else if (branchTaken) begin
                pcNext <= pc + immB;             // Branch target
            end else begin
                pcNext <= pcPlus4;
            end
        end
        if ((state == Isa::MEMORY) && !i_dataBusy) begin
            loadData <= i_dataRdata;             // Ignored for SW
        end
    end

endmodule

/* logic/Processor.sv */
`timescale 1ns/1ps
`include "Processor_settings.svh"

module Processor (
    input  logic           i_clock,      // Clock
    input  logic           i_rst,        // Sync reset, active high
    output Types::InstAddr o_instAddr,   // Instruction memory bus
    output logic           o_instRe,
    input  Types::Inst     i_inst,
    input  logic           i_instBusy,
    output Types::DataAddr o_dataAddr,   // Data memory bus
    output logic           o_dataRe,
    output logic           o_dataWe,
    output Types::Data     o_dataWdata,
    input  Types::Data     i_dataRdata,
    input  logic           i_dataBusy);

    Types::InstAddr coreInstAddr;        // Local instruction bus
    logic           coreInstRe;
    Types::Inst     coreInst;
    logic           coreInstBusy;

    // ---------------------------------------------------------
    // L1 instruction cache or bypass
    // ---------------------------------------------------------

    generate
        if (`RV_ICACHE_ON == 1) begin : iCacheBlock
            InstL1Cache instL1Cache (
                .i_clock    (i_clock),
                .i_rst      (i_rst),
                .i_coreAddr (coreInstAddr),  // Local side
                .i_coreRe   (coreInstRe),
                .o_coreInst (coreInst),
                .o_coreBusy (coreInstBusy),
                .o_memAddr  (o_instAddr),    // Global side
                .o_memRe    (o_instRe),
                .i_memInst  (i_inst),
                .i_memBusy  (i_instBusy));
        end else begin : iBypassBlock
            assign o_instAddr   = coreInstAddr;
            assign o_instRe     = coreInstRe;
            assign coreInst     = i_inst;
            assign coreInstBusy = i_instBusy;
        end
    endgenerate

    // ---------------------------------------------------------
    // Core, data bus wired straight out
    // ---------------------------------------------------------

    CoreMC core (
        .i_clock     (i_clock),
        .i_rst       (i_rst),
        .o_instAddr  (coreInstAddr),
        .o_instRe    (coreInstRe),
        .i_inst      (coreInst),
        .i_instBusy  (coreInstBusy),
        .o_dataAddr  (o_dataAddr),
        .o_dataRe    (o_dataRe),
        .o_dataWe    (o_dataWe),
        .o_dataWdata (o_dataWdata),
        .i_dataRdata (i_dataRdata),
        .i_dataBusy  (i_dataBusy));

endmodule

/* verification/MemoryModels.sv */
`timescale 1ns/1ps

module InstRom (
    input  logic           i_clock,      // Clock
    input  logic           i_stallOn,    // Random busy when high
    input  logic           i_loadEn,     // Program load port
    input  logic [5:0]     i_loadAddr,
    input  Types::Inst     i_loadData,
    input  Types::InstAddr i_addr,       // Global instruction bus
    output Types::Inst     o_inst,
    output logic           o_busy);

    Types::Inst  mem [64];               // 256 bytes in 64 words
    logic        stallBit = 1'b0;
    logic [31:0] rnd;
    integer      seed = 32'h72ad;

    assign o_inst = mem[i_addr[7:2]];    // Async read
    assign o_busy = i_stallOn && stallBit;

    // New stall decision every cycle
    always @(negedge i_clock) begin
        rnd = $random(seed);
        stallBit <= rnd[0];              // About half the cycles
    end

    always @(posedge i_clock) begin
        if (i_loadEn) begin
            mem[i_loadAddr] <= i_loadData;
        end
    end

endmodule

module DataRam (
    input  logic           i_clock,      // Clock
    input  logic           i_rst,        // Refills the address pattern
    input  logic           i_stallOn,    // Random busy when high
    input  Types::DataAddr i_addr,       // Data bus
    input  logic           i_re,         // Read data driven only when high
    input  logic           i_we,
    input  Types::Data     i_wdata,
    output Types::Data     o_rdata,
    output logic           o_busy);

    Types::Data  mem [64];
    logic        stallBit = 1'b0;
    logic [31:0] rnd;
    integer      seed = 32'h72ad;

    assign o_rdata = i_re ? mem[i_addr[7:2]] : '0; // Async read, zero when idle
    assign o_busy  = i_stallOn && stallBit;

    always @(negedge i_clock) begin
        rnd = $random(seed);
        stallBit <= rnd[3];              // Other bit than the ROM
    end

    always @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < 64; i++) begin
                mem[i] <= 32'hD000_0000 | (32'(i) << 2); // Tagged with byte address
            end
        end else if (i_we && !o_busy) begin
            mem[i_addr[7:2]] <= i_wdata; // Write on completion
        end
    end

endmodule

/* verification/ProcessorTb.sv */
`timescale 1ns/1ps
`include "Processor_settings.svh"

module ProcessorTb;

    localparam Types::DataAddr DoneAddr     = 32'h0000_00FC; // Last RAM word
    localparam int             RomWords     = 64;
    localparam int             FetchTimeout = 20;           // Cycles
    localparam int             RunTimeout   = 5000;

    logic           clock = 1'b0;
    logic           rst;
    Types::InstAddr instAddr;
    logic           instRe;
    Types::Inst     inst;
    logic           instBusy;
    Types::DataAddr dataAddr;
    logic           dataRe;
    logic           dataWe;
    Types::Data     dataWdata;
    Types::Data     dataRdata;
    logic           dataBusy;

    logic           stallOn;       // Random busy on both memories
    logic           romLoad;
    logic [5:0]     romLoadAddr;
    Types::Inst     romLoadData;

    int             reads;         // Completed global instruction reads
    int             readsAtDone;
    logic           doneSeen;

    Types::Inst     prog [$];      // Program under test

    always #10 clock = ~clock;     // 20 ns period

    Processor dut0 (
        .i_clock     (clock),
        .i_rst       (rst),
        .o_instAddr  (instAddr),
        .o_instRe    (instRe),
        .i_inst      (inst),
        .i_instBusy  (instBusy),
        .o_dataAddr  (dataAddr),
        .o_dataRe    (dataRe),
        .o_dataWe    (dataWe),
        .o_dataWdata (dataWdata),
        .i_dataRdata (dataRdata),
        .i_dataBusy  (dataBusy));

    InstRom rom0 (
        .i_clock    (clock),
        .i_stallOn  (stallOn),
        .i_loadEn   (romLoad),
        .i_loadAddr (romLoadAddr),
        .i_loadData (romLoadData),
        .i_addr     (instAddr),
        .o_inst     (inst),
        .o_busy     (instBusy));

    DataRam ram0 (
        .i_clock   (clock),
        .i_rst     (rst),
        .i_stallOn (stallOn),
        .i_addr    (dataAddr),
        .i_re      (dataRe),
        .i_we      (dataWe),
        .i_wdata   (dataWdata),
        .o_rdata   (dataRdata),
        .o_busy    (dataBusy));

    // ---------------------------------------------------------
    // Bus monitor
    // ---------------------------------------------------------

    always @(posedge clock) begin
        if (rst) begin
            reads       <= 0;
            readsAtDone <= 0;
            doneSeen    <= 1'b0;
        end else begin
            if (instRe && !instBusy) begin
                reads <= reads + 1;                 // Read completes this cycle
            end
            if (dataWe && !dataBusy && (dataAddr == DoneAddr)) begin
                doneSeen <= 1'b1;
                if (!doneSeen) begin
                    readsAtDone <= reads;           // No fetch during MEMORY
                end
            end
        end
    end

    // ---------------------------------------------------------
    // RV32I encoders
    // ---------------------------------------------------------

    function automatic Types::Inst aluReg(logic [2:0] f3, logic [6:0] f7, Types::RegIdx rd,
                                          Types::RegIdx rs1, Types::RegIdx rs2);
        return {f7, rs2, rs1, f3, rd, Isa::OPC_OP};
    endfunction

    function automatic Types::Inst addImm(Types::RegIdx rd, Types::RegIdx rs1, logic [11:0] imm);
        return {imm, rs1, Isa::F3_ADD, rd, Isa::OPC_OPIMM};
    endfunction

    function automatic Types::Inst loadWord(Types::RegIdx rd, Types::RegIdx rs1,
                                            logic [11:0] imm);
        return {imm, rs1, Isa::F3_LW, rd, Isa::OPC_LOAD};
    endfunction

    function automatic Types::Inst storeWord(Types::RegIdx rs2, Types::RegIdx rs1,
                                             logic [11:0] imm);
        return {imm[11:5], rs2, rs1, Isa::F3_SW, imm[4:0], Isa::OPC_STORE};
    endfunction

    function automatic Types::Inst condBranch(logic [2:0] f3, Types::RegIdx rs1,
                                              Types::RegIdx rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], Isa::OPC_BRANCH};
    endfunction

    function automatic Types::Inst jump(Types::RegIdx rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, Isa::OPC_JAL};
    endfunction

    function automatic Types::Inst upperImm(Types::RegIdx rd, logic [19:0] imm);
        return {imm, rd, Isa::OPC_LUI};
    endfunction

    // ---------------------------------------------------------
    // Helpers
    // ---------------------------------------------------------

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic checkEqual(input string what, input Types::Data got, input Types::Data exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            stopRun("Stopping at the first mismatch");
        end
    endtask

    function automatic Types::Data ramWord(int byteAddr);
        return ram0.mem[byteAddr[7:2]];
    endfunction

    // R-type result straight to memory
    task automatic opThenStore(input logic [2:0] f3, input logic [6:0] f7, input Types::RegIdx rd,
                               input Types::RegIdx rs1, input Types::RegIdx rs2,
                               input logic [11:0] addr);
        prog.push_back(aluReg(f3, f7, rd, rs1, rs2));
        prog.push_back(storeWord(rd, 5'd0, addr));
    endtask

    // Done marker, then park in a self loop
    task automatic finishProgram();
        prog.push_back(storeWord(5'd0, 5'd0, 12'hFC));
        prog.push_back(jump(5'd0, 21'd0));
    endtask

    task automatic runProgram();
        int cycles;
        for (int i = 0; i < RomWords; i++) begin
            @(negedge clock);
            romLoad     = 1'b1;
            romLoadAddr = 6'(i);
            romLoadData = (i < prog.size()) ? prog[i] : addImm(5'd0, 5'd0, 12'(i * 4));
        end
        @(negedge clock);
        romLoad = 1'b0;
        rst     = 1'b1;
        repeat (2) begin
            @(negedge clock);
            checkEqual("enables in reset", {29'd0, instRe, dataRe, dataWe}, 32'd0);
        end
        rst    = 1'b0;
        cycles = 0;
        while (!instRe) begin
            checkEqual("data enables before fetch", {30'd0, dataRe, dataWe}, 32'd0);
            if (cycles == FetchTimeout) begin
                stopRun("Timeout: no instruction fetch after reset");
            end
            @(negedge clock);
            cycles++;
        end
        checkEqual("first fetch address", instAddr, `RV_RESET_PC);
        cycles = 0;
        while (!doneSeen) begin
            if (cycles == RunTimeout) begin
                stopRun("Timeout: the program never stored to the done address");
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    // ---------------------------------------------------------
    // Directed tests
    // ---------------------------------------------------------

    task automatic arithTest();
        Types::Data a;
        Types::Data b;
        $display("Arithmetic test, stalls %0b", stallOn);
        a = {20'h12345, 12'd0} + 32'h678;    // LUI then ADDI
        b = 32'd0 - 32'd5;
        prog.delete();
        prog.push_back(upperImm(5'd1, 20'h12345));
        prog.push_back(addImm(5'd1, 5'd1, 12'h678));
        prog.push_back(addImm(5'd2, 5'd0, -12'sd5));
        opThenStore(Isa::F3_ADD, Isa::F7_BASE, 5'd3, 5'd1, 5'd2, 12'd0);
        opThenStore(Isa::F3_ADD, Isa::F7_SUB, 5'd4, 5'd1, 5'd2, 12'd4);
        opThenStore(Isa::F3_AND, Isa::F7_BASE, 5'd5, 5'd1, 5'd2, 12'd8);
        opThenStore(Isa::F3_OR, Isa::F7_BASE, 5'd6, 5'd1, 5'd2, 12'd12);
        opThenStore(Isa::F3_XOR, Isa::F7_BASE, 5'd7, 5'd1, 5'd2, 12'd16);
        opThenStore(Isa::F3_SLT, Isa::F7_BASE, 5'd8, 5'd2, 5'd1, 12'd20);
        opThenStore(Isa::F3_SLT, Isa::F7_BASE, 5'd9, 5'd1, 5'd2, 12'd24);
        finishProgram();
        runProgram();
        checkEqual("ADD", ramWord(0), a + b);
        checkEqual("SUB", ramWord(4), a - b);
        checkEqual("AND", ramWord(8), a & b);
        checkEqual("OR", ramWord(12), a | b);
        checkEqual("XOR", ramWord(16), a ^ b);
        checkEqual("SLT negative first", ramWord(20), 32'd1);  // -5 below 0x12345678
        checkEqual("SLT positive first", ramWord(24), 32'd0);
    endtask

    task automatic memoryTest();
        $display("Load/store test, stalls %0b", stallOn);
        prog.delete();
        prog.push_back(addImm(5'd1, 5'd0, 12'd100));
        prog.push_back(addImm(5'd2, 5'd0, -12'sd7));
        prog.push_back(addImm(5'd6, 5'd0, 12'd32));   // Base address
        prog.push_back(storeWord(5'd1, 5'd6, 12'd0));
        prog.push_back(storeWord(5'd2, 5'd6, 12'd4));
        prog.push_back(loadWord(5'd3, 5'd6, 12'd0));
        prog.push_back(loadWord(5'd4, 5'd6, 12'd4));
        opThenStore(Isa::F3_ADD, Isa::F7_BASE, 5'd5, 5'd3, 5'd4, 12'd40);
        prog.push_back(addImm(5'd3, 5'd3, 12'd1));
        prog.push_back(storeWord(5'd3, 5'd6, 12'd0));  // Overwrite first word
        prog.push_back(addImm(5'd0, 5'd0, 12'd55));    // x0 write dropped
        prog.push_back(storeWord(5'd0, 5'd6, 12'd16));
        prog.push_back(loadWord(5'd0, 5'd6, 12'd4));   // Load into x0 too
        prog.push_back(storeWord(5'd0, 5'd6, 12'd20));
        finishProgram();
        runProgram();
        checkEqual("modified word", ramWord(32), 32'd101);
        checkEqual("negative word", ramWord(36), 32'd0 - 32'd7);
        checkEqual("sum of loads", ramWord(40), 32'd100 - 32'd7);
        checkEqual("x0 after ADDI", ramWord(48), 32'd0);
        checkEqual("x0 after LW", ramWord(52), 32'd0);
    endtask

    task automatic controlTest();
        Types::Data sum;
        $display("Control flow test, stalls %0b", stallOn);
        sum = 32'd0;
        for (int k = 1; k <= 10; k++) begin
            sum = sum + 32'(k);
        end
        prog.delete();
        prog.push_back(addImm(5'd1, 5'd0, 12'd0));                 // 0  sum
        prog.push_back(addImm(5'd2, 5'd0, 12'd1));                 // 4  i
        prog.push_back(addImm(5'd3, 5'd0, 12'd11));                // 8  limit
        prog.push_back(aluReg(Isa::F3_ADD, Isa::F7_BASE, 5'd1, 5'd1, 5'd2)); // 12
        prog.push_back(addImm(5'd2, 5'd2, 12'd1));                 // 16
        prog.push_back(condBranch(Isa::F3_BNE, 5'd2, 5'd3, -13'sd8)); // 20 back to 12
        prog.push_back(storeWord(5'd1, 5'd0, 12'd64));             // 24
        prog.push_back(condBranch(Isa::F3_BEQ, 5'd0, 5'd0, 13'd8)); // 28 to 36
        prog.push_back(storeWord(5'd3, 5'd0, 12'd68));             // 32 skipped
        prog.push_back(jump(5'd4, 21'd8));                         // 36 to 44
        prog.push_back(storeWord(5'd3, 5'd0, 12'd72));             // 40 skipped
        prog.push_back(storeWord(5'd4, 5'd0, 12'd76));             // 44
        finishProgram();                                           // 48, 52
        runProgram();
        checkEqual("loop sum", ramWord(64), sum);
        checkEqual("BEQ skipped store", ramWord(68), 32'hD000_0000 | 32'd68);
        checkEqual("JAL skipped store", ramWord(72), 32'hD000_0000 | 32'd72);
        checkEqual("JAL link", ramWord(76), 32'd36 + 32'd4);
        // Fetched up to done is everything but the two skipped stores and the self loop
        if (`RV_ICACHE_ON == 1) begin
            checkEqual("cache fills", 32'(readsAtDone), 32'(prog.size() - 3));
        end
    endtask

    // ---------------------------------------------------------
    // Main sequence
    // ---------------------------------------------------------

    initial begin
        rst         = 1'b1;
        stallOn     = 1'b0;
        romLoad     = 1'b0;
        romLoadAddr = '0;
        romLoadData = '0;
        for (int round = 0; round < 2; round++) begin
            stallOn = (round == 1);          // Second round with random busy
            arithTest();
            memoryTest();
            controlTest();
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+logic
logic/Types.sv
logic/Isa.sv
logic/RegisterFile.sv
logic/Alu.sv
logic/InstL1Cache.sv
logic/CoreMC.sv
logic/Processor.sv
verification/MemoryModels.sv
verification/ProcessorTb.sv

/* run.sh */
#!/bin/sh
# Build and run the processor testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module ProcessorTb -f tb.f \
    && ./obj_dir/VProcessorTb \
    || { echo "Simulation did not complete cleanly"; exit 1; }
